//--- tb.f
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/inst_decoder.sv
verilog/operand_bypass.sv
verilog/id_ex_reg.sv
verilog/decode_stage.sv
dv/decode_stage_properties.sv
dv/tb_decode_stage.sv

//--- run.sh
#!/bin/bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_decode_stage \
  -f tb.f -o Vtb_decode_stage > sim.log 2>&1 \
  && ./obj_dir/Vtb_decode_stage >> sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0

//--- dv/tb_decode_stage.sv
`default_nettype none
`timescale 1ns/1ps

module tb_decode_stage import rv_isa_pkg::*; import rv_pipe_pkg::*;;

  localparam int XLEN = 64;
  localparam int NDIR = 12;

  logic clk_i;
  logic rst_n_i;
  logic [31:0] inst_i;
  logic inst_valid_i;
  logic [XLEN-1:0] rs1_data_i, rs2_data_i, ex_rd_data_i, mem_rd_data_i;
  logic [REG_AW-1:0] mem_rd_addr_i;
  logic stall_o, valid_o;
  logic [REG_AW-1:0] rs1_idx_o, rs2_idx_o;
  dec_ctrl_t id_ex_o;
  logic [XLEN-1:0] imm_o, rs1_data_o, rs2_data_o;

  // model of the slot sitting in ex
  logic m_valid;
  logic m_load;
  logic [REG_AW-1:0] m_rd;

  // expectations for the next check
  logic exp_stall, chk_q, bub_q;
  dec_ctrl_t exp_ctrl;
  logic [XLEN-1:0] exp_imm, exp_rs1, exp_rs2;
  logic [REG_AW-1:0] exp_rs1_idx;
  logic [REG_AW-1:0] exp_rs2_idx;
  int errors;

  logic [31:0] dir_inst [NDIR];
  dec_ctrl_t dir_ctrl [NDIR];
  logic [XLEN-1:0] dir_imm [NDIR];

  decode_stage #(.XLEN(XLEN)) UUT (.*);

  bind decode_stage decode_stage_properties u_props (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .stall_o(stall_o),
    .valid_o(valid_o), .id_ex_o(id_ex_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  a_ctrl: assert property (@(negedge clk_i) chk_q |-> (valid_o && id_ex_o == exp_ctrl))
    else begin
      errors++;
      $display("** Error id_ex_o: got %h, expected %h (valid_o %h)", id_ex_o, exp_ctrl, valid_o);
    end
  a_imm: assert property (@(negedge clk_i) chk_q |-> imm_o == exp_imm)
    else begin
      errors++;
      $display("** Error imm_o: got %h, expected %h", imm_o, exp_imm);
    end
  a_rs1: assert property (@(negedge clk_i) chk_q |-> rs1_data_o == exp_rs1)
    else begin
      errors++;
      $display("** Error rs1_data_o: got %h, expected %h", rs1_data_o, exp_rs1);
    end
  a_rs2: assert property (@(negedge clk_i) chk_q |-> rs2_data_o == exp_rs2)
    else begin
      errors++;
      $display("** Error rs2_data_o: got %h, expected %h", rs2_data_o, exp_rs2);
    end
  a_bubble: assert property (@(negedge clk_i) bub_q |-> (!valid_o && id_ex_o == DEC_BUBBLE))
    else begin
      errors++;
      $display("** Error valid_o/id_ex_o: got %h/%h, expected 0/%h", valid_o, id_ex_o,
               DEC_BUBBLE);
    end
  a_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i) stall_o == exp_stall)
    else begin
      errors++;
      $display("** Error stall_o: got %h, expected %h", stall_o, exp_stall);
    end
  // register file read ports follow the current instruction
  a_idx: assert property (@(posedge clk_i)
                          rs1_idx_o == exp_rs1_idx && rs2_idx_o == exp_rs2_idx)
    else begin
      errors++;
      $display("** Error rs1_idx_o/rs2_idx_o: got %h/%h, expected %h/%h", rs1_idx_o,
               rs2_idx_o, exp_rs1_idx, exp_rs2_idx);
    end

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic dec_ctrl_t make_ctrl(logic [4:0] rs1, logic [4:0] rs2, logic [4:0] rd,
                                          alu_op_e alu, mem_op_e mem, exc_op_e exc,
                                          pc_op_e pc);
    dec_ctrl_t c;
    c.rs1_idx = rs1;
    c.rs2_idx = rs2;
    c.rd_idx  = rd;
    c.alu_op  = alu;
    c.mem_op  = mem;
    c.exc_op  = exc;
    c.pc_op   = pc;
    return c;
  endfunction

  function automatic logic ex_match(logic [4:0] idx);
    return m_valid && (idx != 0) && (idx == m_rd);
  endfunction

  // expected operand, youngest producer first
  function automatic logic [XLEN-1:0] expect_operand(logic [4:0] idx, logic [XLEN-1:0] rf);
    if (ex_match(idx))
      return ex_rd_data_i;
    else if ((idx != 0) && (idx == mem_rd_addr_i))
      return mem_rd_data_i;
    return rf;
  endfunction

  task automatic fill_tables();
    dir_inst[0]  = enc_i(12'hffc, 5'd2, 3'b010, 5'd5, opc_load);
    dir_ctrl[0]  = make_ctrl(2, 0, 5, alu_add, mem_lw, exc_load, pc_inc4);
    dir_imm[0]   = 64'hffff_ffff_ffff_fffc;
    dir_inst[1]  = enc_s(12'd16, 5'd7, 5'd3, 3'b011);
    dir_ctrl[1]  = make_ctrl(3, 7, 0, alu_add, mem_sd, exc_store, pc_inc4);
    dir_imm[1]   = 64'd16;
    dir_inst[2]  = enc_b(13'h1ff8, 5'd4, 5'd1, 3'b001);
    dir_ctrl[2]  = make_ctrl(1, 4, 0, alu_bne, mem_none, exc_branch, pc_branch);
    dir_imm[2]   = 64'hffff_ffff_ffff_fff8;
    dir_inst[3]  = enc_i(12'd12, 5'd6, 3'b000, 5'd1, opc_jalr);
    dir_ctrl[3]  = make_ctrl(6, 0, 1, alu_add, mem_none, exc_jalr, pc_jalr);
    dir_imm[3]   = 64'd12;
    dir_inst[4]  = enc_j(21'd2048, 5'd1);
    dir_ctrl[4]  = make_ctrl(0, 0, 1, alu_add, mem_none, exc_jal, pc_jal);
    dir_imm[4]   = 64'd2048;
    dir_inst[5]  = enc_i(12'hfff, 5'd8, 3'b000, 5'd9, opc_op_imm);
    dir_ctrl[5]  = make_ctrl(8, 0, 9, alu_add, mem_none, exc_opimm, pc_inc4);
    dir_imm[5]   = '1;
    dir_inst[6]  = enc_r(7'h20, 5'd12, 5'd11, 3'b000, 5'd10, opc_op);
    dir_ctrl[6]  = make_ctrl(11, 12, 10, alu_sub, mem_none, exc_op, pc_inc4);
    dir_imm[6]   = '0;
    dir_inst[7]  = enc_i(12'd5, 5'd14, 3'b000, 5'd13, opc_op_imm_32);
    dir_ctrl[7]  = make_ctrl(14, 0, 13, alu_add, mem_none, exc_opimm32, pc_inc4);
    dir_imm[7]   = 64'd5;
    dir_inst[8]  = enc_r(7'h20, 5'd17, 5'd16, 3'b101, 5'd15, opc_op_32);
    dir_ctrl[8]  = make_ctrl(16, 17, 15, alu_sraw, mem_none, exc_op32, pc_inc4);
    dir_imm[8]   = '0;
    dir_inst[9]  = {20'h80000, 5'd18, 7'b0010111};
    dir_ctrl[9]  = make_ctrl(0, 0, 18, alu_add, mem_none, exc_auipc, pc_inc4);
    dir_imm[9]   = 64'hffff_ffff_8000_0000;
    dir_inst[10] = {20'h12345, 5'd19, 7'b0110111};
    dir_ctrl[10] = make_ctrl(0, 0, 19, alu_add, mem_none, exc_lui, pc_inc4);
    dir_imm[10]  = 64'h1234_5000;
    // unknown major opcode
    dir_inst[11] = 32'hffff_ffff;
    dir_ctrl[11] = DEC_BUBBLE;
    dir_imm[11]  = '0;
  endtask

  task automatic randomize_data();
    rs1_data_i    = {$urandom, $urandom};
    rs2_data_i    = {$urandom, $urandom};
    ex_rd_data_i  = {$urandom, $urandom};
    mem_rd_data_i = {$urandom, $urandom};
    mem_rd_addr_i = 5'($urandom % 8);
  endtask

  // present one instruction, holding it while the stage stalls
  task automatic issue(logic [31:0] inst, logic vld, dec_ctrl_t ctrl, logic [XLEN-1:0] imm);
    int tries;
    logic stalled;
    logic [XLEN-1:0] r1;
    logic [XLEN-1:0] r2;
    tries = 0;
    stalled = 1'b1;
    while (stalled) begin
      @(negedge clk_i);
      inst_i = inst;
      inst_valid_i = vld;
      randomize_data();
      exp_rs1_idx = ctrl.rs1_idx;
      exp_rs2_idx = ctrl.rs2_idx;
      exp_stall = m_valid && m_load && (ex_match(ctrl.rs1_idx) || ex_match(ctrl.rs2_idx));
      r1 = expect_operand(ctrl.rs1_idx, rs1_data_i);
      r2 = expect_operand(ctrl.rs2_idx, rs2_data_i);
      // stall_o is combinational and settled mid-cycle
      #2;
      stalled = vld && stall_o;
      @(posedge clk_i);
      if (vld && !exp_stall) begin
        m_valid  = 1'b1;
        m_load   = (ctrl.exc_op == exc_load);
        m_rd     = ctrl.rd_idx;
        chk_q    = 1'b1;
        bub_q    = 1'b0;
        exp_ctrl = ctrl;
        exp_imm  = imm;
        exp_rs1  = r1;
        exp_rs2  = r2;
      end else begin
        m_valid = 1'b0;
        chk_q   = 1'b0;
        bub_q   = 1'b1;
      end
      tries++;
      if (stalled && tries > 4) begin
        errors++;
        $display("stall on instruction %h did not clear within 4 cycles", inst);
        stalled = 1'b0;
      end
    end
  endtask

  initial begin
    logic [4:0] rs1, rs2, rd;
    logic [11:0] imm12;
    int kind;
    void'($urandom(32'hf081));
    errors = 0;
    rst_n_i = 1'b0;
    inst_i = '0;
    inst_valid_i = 1'b0;
    rs1_data_i = '0;
    rs2_data_i = '0;
    ex_rd_data_i = '0;
    mem_rd_data_i = '0;
    mem_rd_addr_i = '0;
    m_valid = 1'b0;
    m_load = 1'b0;
    m_rd = '0;
    exp_stall = 1'b0;
    chk_q = 1'b0;
    bub_q = 1'b0;
    exp_ctrl = DEC_BUBBLE;
    exp_imm = '0;
    exp_rs1 = '0;
    exp_rs2 = '0;
    exp_rs1_idx = '0;
    exp_rs2_idx = '0;
    fill_tables();
    @(posedge clk_i);
    // registers are defined from the first reset edge on
    bub_q = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int i = 0; i < NDIR; i++)
      issue(dir_inst[i], 1'b1, dir_ctrl[i], dir_imm[i]);
    // load followed by a dependent add
    issue(enc_i(12'd0, 5'd1, 3'b011, 5'd6, opc_load), 1'b1,
          make_ctrl(1, 0, 6, alu_add, mem_ld, exc_load, pc_inc4), '0);
    issue(enc_r(7'h00, 5'd2, 5'd6, 3'b000, 5'd7, opc_op), 1'b1,
          make_ctrl(6, 2, 7, alu_add, mem_none, exc_op, pc_inc4), '0);
    for (int i = 0; i < 60; i++) begin
      kind = $urandom % 4;
      rs1 = 5'($urandom % 8);
      rs2 = 5'($urandom % 8);
      rd = 5'($urandom % 8);
      imm12 = 12'($urandom % 256);
      if (kind == 0)
        issue(enc_i(imm12, rs1, 3'b011, rd, opc_load), 1'b1,
              make_ctrl(rs1, 0, rd, alu_add, mem_ld, exc_load, pc_inc4), 64'(imm12));
      else
        issue(enc_r(7'h00, rs2, rs1, 3'b000, rd, opc_op), kind != 3,
              make_ctrl(rs1, rs2, rd, alu_add, mem_none, exc_op, pc_inc4), '0);
    end
    // drain with an empty slot
    @(negedge clk_i);
    inst_i = '0;
    inst_valid_i = 1'b0;
    exp_stall = 1'b0;
    exp_rs1_idx = '0;
    exp_rs2_idx = '0;
    @(posedge clk_i);
    m_valid = 1'b0;
    chk_q = 1'b0;
    bub_q = 1'b1;
    @(negedge clk_i);
    // last negedge checks settle before the summary
    #1;
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  initial begin
    #100us;
    $display("simulation timed out");
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/decode_stage_properties.sv
`default_nettype none
`timescale 1ns/1ps

module decode_stage_properties import rv_isa_pkg::*; import rv_pipe_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      stall_o,
  input logic      valid_o,
  input dec_ctrl_t id_ex_o
);

  // only a valid load in ex may hold decode
  p_stall_from_load: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    stall_o |-> (valid_o && id_ex_o.exc_op == exc_load)
  ) else $error("stall raised without a load in ex");

  // a stall edge latches a bubble
  p_stall_bubble: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    stall_o |=> !valid_o
  ) else $error("stall did not insert a bubble");

  // empty slot carries no operation and no destination
  p_bubble_clean: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !valid_o |-> (id_ex_o.exc_op == exc_none && id_ex_o.mem_op == mem_none &&
                  id_ex_o.rd_idx == '0)
  ) else $error("bubble carries control bits");

  p_reset_empty: assert property (
    @(posedge clk_i)
    !rst_n_i |=> (!valid_o && id_ex_o.exc_op == exc_none && !stall_o)
  ) else $error("reset left a valid entry or a stall");

  // a bubble in ex never stalls the next instruction
  p_no_stall_on_bubble: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !valid_o |-> !stall_o
  ) else $error("stall raised behind a bubble");

endmodule

`default_nettype wire

//--- verilog/decode_stage.sv
`default_nettype none
`timescale 1ns/1ps

module decode_stage import rv_isa_pkg::*; import rv_pipe_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // fetch
  input  logic [INST_W-1:0] inst_i,
  input  logic              inst_valid_i,
  output logic              stall_o,
  // register file read ports
  output logic [REG_AW-1:0] rs1_idx_o,
  output logic [REG_AW-1:0] rs2_idx_o,
  input  logic [XLEN-1:0]   rs1_data_i,
  input  logic [XLEN-1:0]   rs2_data_i,
  // bypass sources
  input  logic [XLEN-1:0]   ex_rd_data_i,
  input  logic [REG_AW-1:0] mem_rd_addr_i,
  input  logic [XLEN-1:0]   mem_rd_data_i,
  // to execute
  output dec_ctrl_t         id_ex_o,
  output logic [XLEN-1:0]   imm_o,
  output logic [XLEN-1:0]   rs1_data_o,
  output logic [XLEN-1:0]   rs2_data_o,
  output logic              valid_o
);

  dec_ctrl_t         dec_ctrl;
  logic [XLEN-1:0]   dec_imm;
  logic [XLEN-1:0]   fwd_rs1_data;
  logic [XLEN-1:0]   fwd_rs2_data;
  ex_hit_t           ex_hit;
  logic [REG_AW-1:0] ex_rd_idx;

  assign rs1_idx_o = dec_ctrl.rs1_idx;
  assign rs2_idx_o = dec_ctrl.rs2_idx;

  inst_decoder #(.XLEN(XLEN)) u_dec (
    .inst_i (inst_i),
    .ctrl_o (dec_ctrl),
    .imm_o  (dec_imm)
  );

  operand_bypass #(.XLEN(XLEN)) u_byp (
    .rs1_idx_i     (dec_ctrl.rs1_idx),
    .rs2_idx_i     (dec_ctrl.rs2_idx),
    .ex_rd_idx_i   (ex_rd_idx),
    .ex_rd_data_i  (ex_rd_data_i),
    .mem_rd_addr_i (mem_rd_addr_i),
    .mem_rd_data_i (mem_rd_data_i),
    .rs1_data_i    (rs1_data_i),
    .rs2_data_i    (rs2_data_i),
    .rs1_data_o    (fwd_rs1_data),
    .rs2_data_o    (fwd_rs2_data),
    .hit_o         (ex_hit)
  );

  id_ex_reg #(.XLEN(XLEN)) u_idex (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .ctrl_i       (dec_ctrl),
    .imm_i        (dec_imm),
    .rs1_data_i   (fwd_rs1_data),
    .rs2_data_i   (fwd_rs2_data),
    .hit_i        (ex_hit),
    .ex_rd_idx_o  (ex_rd_idx),
    .stall_o      (stall_o),
    .valid_o      (valid_o),
    .ctrl_o       (id_ex_o),
    .imm_o        (imm_o),
    .rs1_data_o   (rs1_data_o),
    .rs2_data_o   (rs2_data_o)
  );

endmodule

`default_nettype wire

//--- verilog/id_ex_reg.sv
`default_nettype none
`timescale 1ns/1ps

module id_ex_reg import rv_isa_pkg::*; import rv_pipe_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              inst_valid_i,
  input  dec_ctrl_t         ctrl_i,
  input  logic [XLEN-1:0]   imm_i,
  input  logic [XLEN-1:0]   rs1_data_i,
  input  logic [XLEN-1:0]   rs2_data_i,
  input  ex_hit_t           hit_i,
  output logic [REG_AW-1:0] ex_rd_idx_o,
  output logic              stall_o,
  output logic              valid_o,
  output dec_ctrl_t         ctrl_o,
  output logic [XLEN-1:0]   imm_o,
  output logic [XLEN-1:0]   rs1_data_o,
  output logic [XLEN-1:0]   rs2_data_o
);

  logic            valid_q;
  dec_ctrl_t       ctrl_q;
  logic [XLEN-1:0] imm_q;
  logic [XLEN-1:0] rs1_q;
  logic [XLEN-1:0] rs2_q;
  logic            take;

  // load in ex feeding a source of the current instruction
  // load data only exists after mem, so hold id for one cycle
  assign stall_o = valid_q && (ctrl_q.exc_op == exc_load) &&
                   (hit_i.rs1_hit || hit_i.rs2_hit);

  assign take = inst_valid_i && !stall_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      ctrl_q  <= DEC_BUBBLE;
    end else if (take) begin
      valid_q <= 1'b1;
      ctrl_q  <= ctrl_i;
    end else begin
      // bubble
      valid_q <= 1'b0;
      ctrl_q  <= DEC_BUBBLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      imm_q <= imm_i;
      rs1_q <= rs1_data_i;
      rs2_q <= rs2_data_i;
    end
  end

  // an empty slot must not look like a producer
  assign ex_rd_idx_o = valid_q ? ctrl_q.rd_idx : '0;

  assign valid_o    = valid_q;
  assign ctrl_o     = ctrl_q;
  assign imm_o      = imm_q;
  assign rs1_data_o = rs1_q;
  assign rs2_data_o = rs2_q;

endmodule

`default_nettype wire

//--- verilog/operand_bypass.sv
`default_nettype none
`timescale 1ns/1ps

module operand_bypass import rv_isa_pkg::*; import rv_pipe_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic [REG_AW-1:0] rs1_idx_i,
  input  logic [REG_AW-1:0] rs2_idx_i,
  input  logic [REG_AW-1:0] ex_rd_idx_i,
  input  logic [XLEN-1:0]   ex_rd_data_i,
  input  logic [REG_AW-1:0] mem_rd_addr_i,
  input  logic [XLEN-1:0]   mem_rd_data_i,
  input  logic [XLEN-1:0]   rs1_data_i,
  input  logic [XLEN-1:0]   rs2_data_i,
  output logic [XLEN-1:0]   rs1_data_o,
  output logic [XLEN-1:0]   rs2_data_o,
  output ex_hit_t           hit_o
);

  logic rs1_ex_hit;
  logic rs2_ex_hit;
  logic rs1_mem_hit;
  logic rs2_mem_hit;

  // x0 is hardwired, never forward into it
  function automatic logic idx_match(input logic [REG_AW-1:0] src,
                                     input logic [REG_AW-1:0] dst);
    return (src != '0) && (src == dst);
  endfunction

  assign rs1_ex_hit  = idx_match(rs1_idx_i, ex_rd_idx_i);
  assign rs2_ex_hit  = idx_match(rs2_idx_i, ex_rd_idx_i);
  assign rs1_mem_hit = idx_match(rs1_idx_i, mem_rd_addr_i);
  assign rs2_mem_hit = idx_match(rs2_idx_i, mem_rd_addr_i);

  // youngest producer wins: ex, then mem, then register file
  assign rs1_data_o = rs1_ex_hit  ? ex_rd_data_i  :
                      rs1_mem_hit ? mem_rd_data_i : rs1_data_i;
  assign rs2_data_o = rs2_ex_hit  ? ex_rd_data_i  :
                      rs2_mem_hit ? mem_rd_data_i : rs2_data_i;

  assign hit_o.rs1_hit = rs1_ex_hit;
  assign hit_o.rs2_hit = rs2_ex_hit;

endmodule

`default_nettype wire

//--- verilog/inst_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module inst_decoder import rv_isa_pkg::*; import rv_pipe_pkg::*; #(
  parameter int XLEN = 64
) (
  input  logic [INST_W-1:0] inst_i,
  output dec_ctrl_t         ctrl_o,
  output logic [XLEN-1:0]   imm_o
);

  opcode_e           opc;
  logic [REG_AW-1:0] rd;
  logic [REG_AW-1:0] rs1;
  logic [REG_AW-1:0] rs2;
  logic [2:0]        funct3;
  logic [6:0]        funct7;

  // instruction format, set only for a legal encoding
  logic type_r, type_i, type_s, type_b, type_u, type_j;
  logic legal;

  alu_op_e alu;
  mem_op_e mem;
  exc_op_e exc;
  pc_op_e  pc;

  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

  assign opc    = opcode_e'(inst_i[6:0]);
  assign rd     = inst_i[11:7];
  assign funct3 = inst_i[14:12];
  assign rs1    = inst_i[19:15];
  assign rs2    = inst_i[24:20];
  assign funct7 = inst_i[31:25];

  // bit 31 is the sign for every format
  assign imm_i = {{(XLEN-11){inst_i[31]}}, inst_i[30:20]};
  assign imm_s = {{(XLEN-11){inst_i[31]}}, inst_i[30:25], inst_i[11:7]};
  assign imm_b = {{(XLEN-12){inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{(XLEN-31){inst_i[31]}}, inst_i[30:12], 12'b0};
  assign imm_j = {{(XLEN-20){inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  always_comb begin
    alu    = alu_none;
    mem    = mem_none;
    exc    = exc_none;
    pc     = pc_inc4;
    type_r = 1'b0;
    type_i = 1'b0;
    type_s = 1'b0;
    type_b = 1'b0;
    type_u = 1'b0;
    type_j = 1'b0;
    legal  = 1'b1;
    case (opc)
      opc_load: begin
        type_i = 1'b1;
        exc    = exc_load;
        alu    = alu_add;
        case (funct3)
          3'b000:  mem = mem_lb;
          3'b001:  mem = mem_lh;
          3'b010:  mem = mem_lw;
          3'b011:  mem = mem_ld;
          3'b100:  mem = mem_lbu;
          3'b101:  mem = mem_lhu;
          3'b110:  mem = mem_lwu;
          default: legal = 1'b0;
        endcase
      end
      opc_store: begin
        type_s = 1'b1;
        exc    = exc_store;
        alu    = alu_add;
        case (funct3)
          3'b000:  mem = mem_sb;
          3'b001:  mem = mem_sh;
          3'b010:  mem = mem_sw;
          3'b011:  mem = mem_sd;
          default: legal = 1'b0;
        endcase
      end
      opc_branch: begin
        type_b = 1'b1;
        exc    = exc_branch;
        pc     = pc_branch;
        case (funct3)
          3'b000:  alu = alu_beq;
          3'b001:  alu = alu_bne;
          3'b100:  alu = alu_blt;
          3'b101:  alu = alu_bge;
          3'b110:  alu = alu_bltu;
          3'b111:  alu = alu_bgeu;
          default: legal = 1'b0;
        endcase
      end
      opc_jalr: begin
        type_i = 1'b1;
        exc    = exc_jalr;
        pc     = pc_jalr;
        alu    = alu_add;
        legal  = (funct3 == 3'b000);
      end
      opc_jal: begin
        type_j = 1'b1;
        exc    = exc_jal;
        pc     = pc_jal;
        alu    = alu_add;
      end
      opc_op_imm: begin
        type_i = 1'b1;
        exc    = exc_opimm;
        // rv64 shamt is six bits, so only funct7[6:1] selects the shift
        case (funct3)
          3'b000:  alu = alu_add;
          3'b010:  alu = alu_slt;
          3'b011:  alu = alu_sltu;
          3'b100:  alu = alu_xor;
          3'b110:  alu = alu_or;
          3'b111:  alu = alu_and;
          3'b001: begin
            alu   = alu_sll;
            legal = (funct7[6:1] == 6'b000000);
          end
          default: begin
            alu   = funct7[5] ? alu_sra : alu_srl;
            legal = ({funct7[6], funct7[4:1]} == 5'b00000);
          end
        endcase
      end
      opc_op, opc_op_32: begin
        type_r = 1'b1;
        exc    = (opc == opc_op) ? exc_op : exc_op32;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu = alu_add;
          {7'h20, 3'b000}: alu = alu_sub;
          {7'h00, 3'b001}: alu = (opc == opc_op) ? alu_sll : alu_sllw;
          {7'h00, 3'b101}: alu = (opc == opc_op) ? alu_srl : alu_srlw;
          {7'h20, 3'b101}: alu = (opc == opc_op) ? alu_sra : alu_sraw;
          default: begin
            // compare and logic ops have no word form
            legal = (opc == opc_op) && (funct7 == 7'h00);
            case (funct3)
              3'b010:  alu = alu_slt;
              3'b011:  alu = alu_sltu;
              3'b100:  alu = alu_xor;
              3'b110:  alu = alu_or;
              default: alu = alu_and;
            endcase
          end
        endcase
      end
      opc_op_imm_32: begin
        type_i = 1'b1;
        exc    = exc_opimm32;
        case ({funct7, funct3})
          {7'h00, 3'b001}: alu = alu_sllw;
          {7'h00, 3'b101}: alu = alu_srlw;
          {7'h20, 3'b101}: alu = alu_sraw;
          default: begin
            alu   = alu_add;
            legal = (funct3 == 3'b000);
          end
        endcase
      end
      opc_auipc, opc_lui: begin
        type_u = 1'b1;
        exc    = (opc == opc_lui) ? exc_lui : exc_auipc;
        alu    = alu_add;
      end
      default: legal = 1'b0;
    endcase
    // anything unrecognised decodes as an empty slot
    if (!legal) begin
      alu    = alu_none;
      mem    = mem_none;
      exc    = exc_none;
      pc     = pc_inc4;
      type_r = 1'b0;
      type_i = 1'b0;
      type_s = 1'b0;
      type_b = 1'b0;
      type_u = 1'b0;
      type_j = 1'b0;
    end
  end

  // unused register indices read as x0
  assign ctrl_o.rs1_idx = (type_r | type_i | type_s | type_b) ? rs1 : '0;
  assign ctrl_o.rs2_idx = (type_r | type_s | type_b) ? rs2 : '0;
  assign ctrl_o.rd_idx  = (type_r | type_i | type_u | type_j) ? rd : '0;
  assign ctrl_o.alu_op  = alu;
  assign ctrl_o.mem_op  = mem;
  assign ctrl_o.exc_op  = exc;
  assign ctrl_o.pc_op   = pc;

  assign imm_o = ({XLEN{type_i}} & imm_i) |
                 ({XLEN{type_s}} & imm_s) |
                 ({XLEN{type_b}} & imm_b) |
                 ({XLEN{type_u}} & imm_u) |
                 ({XLEN{type_j}} & imm_j);

endmodule

`default_nettype wire

//--- verilog/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  import rv_isa_pkg::*;

  // decode control as it travels from id into ex
  typedef struct packed {
    logic [REG_AW-1:0] rs1_idx;
    logic [REG_AW-1:0] rs2_idx;
    logic [REG_AW-1:0] rd_idx;
    alu_op_e           alu_op;
    mem_op_e           mem_op;
    exc_op_e           exc_op;
    pc_op_e            pc_op;
  } dec_ctrl_t;

  // source matches the destination sitting in ex
  typedef struct packed {
    logic rs1_hit;
    logic rs2_hit;
  } ex_hit_t;

  // control word of an empty slot
  parameter dec_ctrl_t DEC_BUBBLE = '{
    rs1_idx: '0, rs2_idx: '0, rd_idx: '0,
    alu_op: alu_none, mem_op: mem_none, exc_op: exc_none, pc_op: pc_inc4
  };

endpackage

`default_nettype wire

//--- verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // field widths
  parameter int INST_W    = 32;
  parameter int REG_AW    = 5;
  parameter int OPC_W     = 7;
  parameter int ALU_OP_W  = 5;
  parameter int MEM_OP_W  = 4;
  parameter int EXC_OP_W  = 4;
  parameter int PC_OP_W   = 3;

  // rv64i major opcodes handled by this stage
  typedef enum logic [OPC_W-1:0] {
    opc_load      = 7'b0000011,
    opc_store     = 7'b0100011,
    opc_branch    = 7'b1100011,
    opc_jalr      = 7'b1100111,
    opc_jal       = 7'b1101111,
    opc_op_imm    = 7'b0010011,
    opc_op        = 7'b0110011,
    opc_op_imm_32 = 7'b0011011,
    opc_op_32     = 7'b0111011,
    opc_auipc     = 7'b0010111,
    opc_lui       = 7'b0110111
  } opcode_e;

  // branch compares are resolved by the alu as well
  typedef enum logic [ALU_OP_W-1:0] {
    alu_none, alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_srl, alu_sra, alu_sllw, alu_srlw, alu_sraw,
    alu_slt, alu_sltu,
    alu_beq, alu_bne, alu_blt, alu_bge, alu_bltu, alu_bgeu
  } alu_op_e;

  typedef enum logic [MEM_OP_W-1:0] {
    mem_none, mem_lb, mem_lh, mem_lw, mem_ld, mem_lbu, mem_lhu, mem_lwu,
    mem_sb, mem_sh, mem_sw, mem_sd
  } mem_op_e;

  // execute class, one per major opcode
  typedef enum logic [EXC_OP_W-1:0] {
    exc_none, exc_auipc, exc_lui, exc_jal, exc_jalr, exc_load, exc_store,
    exc_branch, exc_opimm, exc_opimm32, exc_op, exc_op32
  } exc_op_e;

  typedef enum logic [PC_OP_W-1:0] {
    pc_inc4, pc_branch, pc_jal, pc_jalr
  } pc_op_e;

endpackage

`default_nettype wire
